// File: tb.f
+incdir+.
mcycleOpPkg.sv
mcycleCtrlPkg.sv
mcycleDecode.sv
mcycleSequencer.sv
mcycleDatapath.sv
mcycleExecute.sv
mcycleResult.sv
mcycleTop.sv
tbMcycle.sv

// File: Bender.yml
package:
  name: mcycle

sources:
  - mcycleOpPkg.sv
  - mcycleCtrlPkg.sv
  - mcycleDecode.sv
  - mcycleSequencer.sv
  - mcycleDatapath.sv
  - mcycleExecute.sv
  - mcycleResult.sv
  - mcycleTop.sv
  - target: test
    include_dirs:
      - .
    files:
      - tbMcycle.sv

// File: tbMcycleTasks.svh
`ifndef TB_MCYCLE_TASKS_SVH
`define TB_MCYCLE_TASKS_SVH

////////////////////////////////////////////////////////////////////////
// Reference model and compares
////////////////////////////////////////////////////////////////////////

function automatic mcycleRes_t expectedResult(input mcycleReq_t r);
    logic [63:0] product;
    mcycleRes_t  e;
    product = 64'(r.operand1) * 64'(r.operand2);
    e.dest  = r.dest;
    case (r.op)
        opMulLo:   e.data = product[31:0];
        opMulHi:   e.data = product[63:32];
        // Divide by zero gives all ones and the dividend back
        opDivQuot: e.data = (r.operand2 == 0) ? '1 : r.operand1 / r.operand2;
        default:   e.data = (r.operand2 == 0) ? r.operand1 : r.operand1 % r.operand2;
    endcase
    return e;
endfunction

task automatic compareResult(input mcycleRes_t got, input mcycleRes_t exp);
    if (got !== exp) begin
        $display("error at %0t: result got data %h dest %0d, expected data %h dest %0d",
                 $time, got.data, got.dest, exp.data, exp.dest);
        errorCount++;
    end
endtask

task automatic compareCount(input int got, input int exp, input string what);
    if (got != exp) begin
        $display("error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        errorCount++;
    end
endtask

////////////////////////////////////////////////////////////////////////
// Drivers and waits
////////////////////////////////////////////////////////////////////////

// Called on a falling edge and returns on the next one
task automatic sendReq(input mcycleOp_e op, input logic [dataWidth-1:0] a,
                       input logic [dataWidth-1:0] b, input logic [tagWidth-1:0] dest);
    mcycleReq_t r;
    r.op       = op;
    r.operand1 = a;
    r.operand2 = b;
    r.dest     = dest;
    while (inCredits == 0) begin
        @(negedge CLK);
    end
    req      = r;
    reqValid = 1'b1;
    inCredits--;
    expQ.push_back(expectedResult(r));
    @(negedge CLK);
    reqValid = 1'b0;
endtask

task automatic sendRandomReq();
    logic [31:0] ctrl;
    logic [31:0] a;
    logic [31:0] b;
    ctrl = lcgNext();
    a    = lcgNext();
    b    = lcgNext();
    // Spread divisor magnitudes
    b    = b >> ctrl[4:0];
    sendReq(mcycleOp_e'(ctrl[31:30]), a, b, ctrl[27:24]);
endtask

// Also waits for the consumer to return every credit it owes
task automatic drainResults(input int limit);
    int cycles;
    cycles = 0;
    while ((expQ.size() != 0 || owed != 0) && cycles < limit) begin
        @(negedge CLK);
        cycles++;
    end
    if (expQ.size() != 0 || owed != 0) begin
        $display("results still missing after %0d cycles, %0d outstanding", limit, expQ.size());
        errorCount++;
    end
    @(negedge CLK);
endtask

task automatic waitCreditPulses(input int target, input int limit);
    int cycles;
    cycles = 0;
    while (creditPulses < target && cycles < limit) begin
        @(negedge CLK);
        cycles++;
    end
endtask

task automatic finishTest(input string name, input int errorsBefore);
    testsRun++;
    if (errorCount == errorsBefore) begin
        testsOk++;
        $display("%s: ok", name);
    end else begin
        testsBad++;
        $display("%s: %0d errors", name, errorCount - errorsBefore);
    end
endtask

////////////////////////////////////////////////////////////////////////
// Directed tests
////////////////////////////////////////////////////////////////////////

task automatic idleAfterReset();
    int errorsBefore;
    int pulses0;
    int highCycles;
    errorsBefore = errorCount;
    pulses0      = creditPulses;
    highCycles   = 0;
    repeat (40) begin
        @(negedge CLK);
        if (outValid !== 1'b0) begin
            highCycles++;
        end
    end
    compareCount(highCycles, 0, "outValid high cycles while idle");
    compareCount(creditPulses - pulses0, 0, "reqCredit pulses while idle");
    finishTest("resetState", errorsBefore);
endtask

task automatic multiplyPairs();
    int errorsBefore;
    errorsBefore = errorCount;
    sendReq(opMulLo, 32'h0, 32'h1234_5678, 4'd1);
    sendReq(opMulHi, 32'h0, 32'h1234_5678, 4'd2);
    sendReq(opMulLo, 32'hffff_ffff, 32'hffff_ffff, 4'd3);
    sendReq(opMulHi, 32'hffff_ffff, 32'hffff_ffff, 4'd4);
    sendReq(opMulLo, 32'd3, 32'd5, 4'd5);
    sendReq(opMulHi, 32'd3, 32'd5, 4'd6);
    sendReq(opMulLo, 32'h0001_0000, 32'h0001_0000, 4'd7);
    sendReq(opMulHi, 32'h0001_0000, 32'h0001_0000, 4'd8);
    sendReq(opMulLo, 32'hdead_beef, 32'd7, 4'd9);
    sendReq(opMulHi, 32'hdead_beef, 32'd7, 4'd10);
    drainResults(10 * 40);
    finishTest("multiply", errorsBefore);
endtask

task automatic dividePairs();
    int errorsBefore;
    errorsBefore = errorCount;
    sendReq(opDivQuot, 32'd100, 32'd1, 4'd11);
    sendReq(opDivRem, 32'd100, 32'd1, 4'd12);
    sendReq(opDivQuot, 32'd5, 32'd9, 4'd13);
    sendReq(opDivRem, 32'd5, 32'd9, 4'd14);
    sendReq(opDivQuot, 32'h1234_5678, 32'd0, 4'd15);
    sendReq(opDivRem, 32'h1234_5678, 32'd0, 4'd0);
    sendReq(opDivQuot, 32'd1000, 32'd7, 4'd1);
    sendReq(opDivRem, 32'd1000, 32'd7, 4'd2);
    sendReq(opDivQuot, 32'hffff_ffff, 32'd3, 4'd3);
    sendReq(opDivRem, 32'hffff_ffff, 32'd3, 4'd4);
    drainResults(10 * 40);
    finishTest("divide", errorsBefore);
endtask

task automatic randomStream();
    int errorsBefore;
    int pulses0;
    errorsBefore = errorCount;
    pulses0      = creditPulses;
    repeat (20) begin
        sendRandomReq();
    end
    drainResults(20 * 40);
    compareCount(creditPulses - pulses0, 20, "reqCredit pulses in random stream");
    finishTest("randomStream", errorsBefore);
endtask

task automatic outputBackPressure();
    int   errorsBefore;
    int   pulses0;
    int   rx0;
    logic sendsDone;
    errorsBefore = errorCount;
    pulses0      = creditPulses;
    rx0          = rxTotal;
    sendsDone    = 1'b0;
    consumerOn   = 1'b0;
    fork
        begin
            repeat (8) begin
                sendRandomReq();
            end
            sendsDone = 1'b1;
        end
    join_none
    // Takes stop once the sent results and a full queue are used up
    waitCreditPulses(pulses0 + outCredits + resDepth, 8 * 40);
    repeat (60) @(negedge CLK);
    compareCount(rxTotal - rx0, outCredits, "results without returned credits");
    compareCount(creditPulses - pulses0, outCredits + resDepth, "reqCredit pulses while stalled");
    consumerOn = 1'b1;
    drainResults(8 * 40);
    compareCount(rxTotal - rx0, 8, "results after credits resume");
    compareCount(creditPulses - pulses0, 8, "reqCredit pulses after credits resume");
    if (!sendsDone) begin
        $display("upstream could not send all 8 requests");
        errorCount++;
    end
    finishTest("backPressure", errorsBefore);
endtask

`endif

// File: tbMcycle.sv
`timescale 1ns/1ps

module tbMcycle
    import mcycleOpPkg::*;
();

    localparam int inDepth    = 2;
    localparam int resDepth   = 4;
    localparam int outCredits = 2;

    // Operations issued by all tests together
    localparam int    totalOps    = 48;
    localparam longint watchdogNs = totalOps * 40 * 20 + 2000;

    logic       CLK;
    logic       Reset;
    logic       reqValid;
    mcycleReq_t req;
    logic       outCredit;
    logic       reqCredit;
    logic       outValid;
    mcycleRes_t out;

    // Upstream and consumer model state
    int          inCredits;
    int          creditPulses;
    int          rxTotal;
    int          owed;
    logic        consumerOn;
    mcycleRes_t  expQ[$];

    // Bookkeeping for the report
    int          errorCount;
    int          testsRun;
    int          testsOk;
    int          testsBad;
    logic [31:0] lcgState;

    mcycleTop #(
        .inDepth    (inDepth),
        .resDepth   (resDepth),
        .outCredits (outCredits)
    ) uut (
        .CLK       (CLK),
        .Reset     (Reset),
        .reqValid  (reqValid),
        .req       (req),
        .outCredit (outCredit),
        .reqCredit (reqCredit),
        .outValid  (outValid),
        .out       (out)
    );

    function logic [31:0] lcgNext();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    `include "tbMcycleTasks.svh"

    ////////////////////////////////////////////////////////////////////
    // Clock, reset and watchdog
    ////////////////////////////////////////////////////////////////////

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    initial begin
        #(watchdogNs);
        $display("run timed out after %0d ns, the DUT stopped responding", watchdogNs);
        $display("test failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////
    // Upstream credits and writeback consumer
    ////////////////////////////////////////////////////////////////////

    always @(posedge CLK) begin
        if (!Reset && reqCredit) begin
            inCredits++;
            creditPulses++;
        end
    end

    // Results are checked in arrival order
    always @(posedge CLK) begin : consumerCheck
        mcycleRes_t expRes;
        if (!Reset && outValid) begin
            rxTotal++;
            owed++;
            if (expQ.size() == 0) begin
                $display("result for dest %0d arrived with no request outstanding", out.dest);
                errorCount++;
            end else begin
                expRes = expQ.pop_front();
                compareResult(out, expRes);
            end
        end
    end

    // One credit back per received result while allowed
    always @(negedge CLK) begin
        outCredit = 1'b0;
        if (!Reset && consumerOn && owed > 0) begin
            outCredit = 1'b1;
            owed--;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////

    initial begin
        Reset        = 1'b1;
        reqValid     = 1'b0;
        req          = '0;
        outCredit    = 1'b0;
        inCredits    = inDepth;
        creditPulses = 0;
        rxTotal      = 0;
        owed         = 0;
        consumerOn   = 1'b1;
        errorCount   = 0;
        testsRun     = 0;
        testsOk      = 0;
        testsBad     = 0;
        lcgState     = 32'hc15b;

        repeat (16) @(posedge CLK);
        @(negedge CLK);
        Reset = 1'b0;

        idleAfterReset();
        multiplyPairs();
        dividePairs();
        randomStream();
        outputBackPressure();

        $display("tests run %0d, ok %0d, bad %0d, errors %0d",
                 testsRun, testsOk, testsBad, errorCount);
        if (errorCount == 0 && testsBad == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: mcycleTop.sv
`timescale 1ns/1ps

module mcycleTop
    import mcycleOpPkg::*;
#(
    parameter int inDepth    = 2,
    parameter int resDepth   = 4,
    parameter int outCredits = 2
) (
    input  logic       CLK,
    input  logic       Reset,
    input  logic       reqValid,
    input  mcycleReq_t req,
    input  logic       outCredit,
    output logic       reqCredit,
    output logic       outValid,
    output mcycleRes_t out
);

    logic       cmdValid;
    mcycleCmd_t cmd;
    logic       cmdTake;
    logic       resSlotFree;
    logic       resPush;
    mcycleRes_t res;

    mcycleDecode #(
        .inDepth (inDepth)
    ) decode (
        .CLK       (CLK),
        .Reset     (Reset),
        .reqValid  (reqValid),
        .req       (req),
        .cmdTake   (cmdTake),
        .reqCredit (reqCredit),
        .cmdValid  (cmdValid),
        .cmd       (cmd)
    );

    mcycleExecute execute (
        .CLK         (CLK),
        .Reset       (Reset),
        .cmdValid    (cmdValid),
        .cmd         (cmd),
        .resSlotFree (resSlotFree),
        .cmdTake     (cmdTake),
        .resPush     (resPush),
        .res         (res)
    );

    mcycleResult #(
        .resDepth   (resDepth),
        .outCredits (outCredits)
    ) result (
        .CLK         (CLK),
        .Reset       (Reset),
        .resPush     (resPush),
        .res         (res),
        .outCredit   (outCredit),
        .resSlotFree (resSlotFree),
        .outValid    (outValid),
        .out         (out)
    );

endmodule

// File: mcycleResult.sv
`timescale 1ns/1ps

module mcycleResult
    import mcycleOpPkg::*;
#(
    parameter int resDepth   = 4,
    parameter int outCredits = 2
) (
    input  logic       CLK,
    input  logic       Reset,
    input  logic       resPush,
    input  mcycleRes_t res,
    input  logic       outCredit,
    output logic       resSlotFree,
    output logic       outValid,
    output mcycleRes_t out
);

    localparam int ptrWidth  = (resDepth > 1) ? $clog2(resDepth) : 1;
    localparam int cntWidth  = $clog2(resDepth + 1);
    localparam int credWidth = $clog2(outCredits + 1);

    mcycleRes_t           queueMem [resDepth];
    logic [ptrWidth-1:0]  wrPtr;
    logic [ptrWidth-1:0]  rdPtr;
    logic [cntWidth-1:0]  count;
    logic [credWidth-1:0] credits;
    logic                 send;

    function automatic logic [ptrWidth-1:0] nextPtr(input logic [ptrWidth-1:0] ptr);
        if (ptr == ptrWidth'(resDepth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge CLK) begin
        if (resPush) begin
            queueMem[wrPtr] <= res;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Queue and credit bookkeeping
    ////////////////////////////////////////////////////////////////////

    assign send = (count != '0) && (credits != '0);

    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            wrPtr   <= '0;
            rdPtr   <= '0;
            count   <= '0;
            credits <= credWidth'(outCredits);
        end else begin
            if (resPush) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (send) begin
                rdPtr <= nextPtr(rdPtr);
            end
            case ({resPush, send})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            case ({send, outCredit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    // One slot kept for the operation about to start
    assign resSlotFree = (count < cntWidth'(resDepth));
    assign outValid    = send;
    assign out         = queueMem[rdPtr];

    pushWhenFull: assert property (@(posedge CLK) disable iff (Reset)
        !(resPush && (count == cntWidth'(resDepth))))
        else $error("result pushed into full queue");

    creditOverflow: assert property (@(posedge CLK) disable iff (Reset)
        credits <= credWidth'(outCredits))
        else $error("consumer returned more credits than granted");

endmodule

// File: mcycleExecute.sv
`timescale 1ns/1ps

module mcycleExecute
    import mcycleOpPkg::*, mcycleCtrlPkg::*;
(
    input  logic       CLK,
    input  logic       Reset,
    input  logic       cmdValid,
    input  mcycleCmd_t cmd,
    input  logic       resSlotFree,
    output logic       cmdTake,
    output logic       resPush,
    output mcycleRes_t res
);

    logic                 load;
    logic                 shift;
    logic                 done;
    logic                 busy;
    logic [dataWidth-1:0] workHigh;
    logic [dataWidth-1:0] workLow;
    mcycleCmd_t           cmdHeld;

    assign cmdTake = !busy && cmdValid && resSlotFree;

    // Command leaves the decode buffer on take and is held for the run
    always_ff @(posedge CLK) begin
        if (cmdTake) begin
            cmdHeld <= cmd;
        end
    end

    mcycleSequencer sequencer (
        .CLK   (CLK),
        .Reset (Reset),
        .start (cmdTake),
        .load  (load),
        .shift (shift),
        .done  (done),
        .busy  (busy)
    );

    mcycleDatapath datapath (
        .CLK      (CLK),
        .Reset    (Reset),
        .load     (load),
        .shift    (shift),
        .cmd      (cmdHeld),
        .workHigh (workHigh),
        .workLow  (workLow)
    );

    assign resPush = done;

    always_comb begin
        res.data = cmdHeld.takeHigh ? workHigh : workLow;
        res.dest = cmdHeld.dest;
    end

    // Load plus iterations plus done
    fixedLatency: assert property (@(posedge CLK) disable iff (Reset)
        cmdTake |-> ##(iterCount + 2) resPush)
        else $error("result not pushed at fixed latency after take");

endmodule

// File: mcycleDatapath.sv
`timescale 1ns/1ps

module mcycleDatapath
    import mcycleOpPkg::*;
(
    input  logic                 CLK,
    input  logic                 Reset,
    input  logic                 load,
    input  logic                 shift,
    input  mcycleCmd_t           cmd,
    output logic [dataWidth-1:0] workHigh,
    output logic [dataWidth-1:0] workLow
);

    logic [2*dataWidth-1:0] workReg;
    logic [dataWidth-1:0]   shiftedOp;
    logic                   isDivReg;
    logic [dataWidth-1:0]   addA;
    logic [dataWidth-1:0]   addB;
    logic [dataWidth-1:0]   addSum;
    logic                   addCarry;
    logic                   divFits;

    assign workHigh = workReg[2*dataWidth-1 -: dataWidth];
    assign workLow  = workReg[dataWidth-1:0];

    ////////////////////////////////////////////////////////////////////
    // Shared adder
    ////////////////////////////////////////////////////////////////////

    // Divide subtracts from the partial remainder already shifted by one
    assign addA = isDivReg ? {workHigh[dataWidth-2:0], workLow[dataWidth-1]} : workHigh;
    assign addB = isDivReg ? ~shiftedOp : shiftedOp;
    assign {addCarry, addSum} = {1'b0, addA} + {1'b0, addB} + {{dataWidth{1'b0}}, isDivReg};

    // Bit lost off the top means the remainder already exceeds the divisor
    assign divFits = addCarry | workHigh[dataWidth-1];

    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            isDivReg <= 1'b0;
        end else if (load) begin
            isDivReg <= cmd.isDiv;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Working register
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLK) begin
        if (load) begin
            workReg   <= {{dataWidth{1'b0}}, cmd.isDiv ? cmd.operand1 : cmd.operand2};
            shiftedOp <= cmd.isDiv ? cmd.operand2 : cmd.operand1;
        end else if (shift) begin
            if (!isDivReg) begin
                // Shift-add on the multiplier's low bit
                if (workReg[0]) begin
                    workReg <= {addCarry, addSum, workLow[dataWidth-1:1]};
                end else begin
                    workReg <= {1'b0, workReg[2*dataWidth-1:1]};
                end
            end else if (divFits) begin
                workReg <= {addSum, workLow[dataWidth-2:0], 1'b1};
            end else begin
                // Restore with quotient bit 0
                workReg <= {workReg[2*dataWidth-2:0], 1'b0};
            end
        end
    end

endmodule

// File: mcycleSequencer.sv
`timescale 1ns/1ps

module mcycleSequencer
    import mcycleCtrlPkg::*;
(
    input  logic CLK,
    input  logic Reset,
    input  logic start,
    output logic load,
    output logic shift,
    output logic done,
    output logic busy
);

    seqState_e               state;
    seqState_e               stateNext;
    logic [iterCntWidth-1:0] iterCnt;
    logic                    lastIter;

    assign lastIter = (iterCnt == iterCntWidth'(iterCount - 1));

    always_comb begin
        stateNext = state;
        case (state)
            seqIdle: begin
                if (start) begin
                    stateNext = seqLoad;
                end
            end
            seqLoad: stateNext = seqRun;
            seqRun: begin
                if (lastIter) begin
                    stateNext = seqDone;
                end
            end
            seqDone: stateNext = seqIdle;
            default: stateNext = seqIdle;
        endcase
    end

    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            state   <= seqIdle;
            iterCnt <= '0;
        end else begin
            state <= stateNext;
            // Counter only runs during iterations
            if (state == seqRun) begin
                iterCnt <= iterCnt + 1'b1;
            end else begin
                iterCnt <= '0;
            end
        end
    end

    assign load  = (state == seqLoad);
    assign shift = (state == seqRun);
    assign done  = (state == seqDone);
    assign busy  = (state != seqIdle);

    startWhileBusy: assert property (@(posedge CLK) disable iff (Reset)
        start |-> (state == seqIdle))
        else $error("start seen outside idle state");

endmodule

// File: mcycleDecode.sv
`timescale 1ns/1ps

module mcycleDecode
    import mcycleOpPkg::*;
#(
    parameter int inDepth = 2
) (
    input  logic       CLK,
    input  logic       Reset,
    input  logic       reqValid,
    input  mcycleReq_t req,
    input  logic       cmdTake,
    output logic       reqCredit,
    output logic       cmdValid,
    output mcycleCmd_t cmd
);

    localparam int ptrWidth = (inDepth > 1) ? $clog2(inDepth) : 1;
    localparam int cntWidth = $clog2(inDepth + 1);

    mcycleReq_t          bufMem [inDepth];
    logic [ptrWidth-1:0] wrPtr;
    logic [ptrWidth-1:0] rdPtr;
    logic [cntWidth-1:0] count;
    mcycleReq_t          head;

    function automatic logic [ptrWidth-1:0] nextPtr(input logic [ptrWidth-1:0] ptr);
        if (ptr == ptrWidth'(inDepth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge CLK) begin
        if (reqValid) begin
            bufMem[wrPtr] <= req;
        end
    end

    // Credit goes back one cycle after the entry leaves
    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            wrPtr     <= '0;
            rdPtr     <= '0;
            count     <= '0;
            reqCredit <= 1'b0;
        end else begin
            reqCredit <= cmdTake;
            if (reqValid) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (cmdTake) begin
                rdPtr <= nextPtr(rdPtr);
            end
            case ({reqValid, cmdTake})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign cmdValid = (count != '0);
    assign head     = bufMem[rdPtr];

    // Head decode
    always_comb begin
        cmd.isDiv    = (head.op == opDivQuot) || (head.op == opDivRem);
        cmd.takeHigh = (head.op == opMulHi) || (head.op == opDivRem);
        cmd.operand1 = head.operand1;
        cmd.operand2 = head.operand2;
        cmd.dest     = head.dest;
    end

    // Upstream only sends against a held credit
    creditOverrun: assert property (@(posedge CLK) disable iff (Reset)
        !(reqValid && (count == cntWidth'(inDepth))))
        else $error("request arrived while decode buffer was full");

endmodule

// File: mcycleCtrlPkg.sv
package mcycleCtrlPkg;

    ////////////////////////////////////////////////////////////////////
    // Sequencer control
    ////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        seqIdle = 2'b00,
        seqLoad = 2'b01,
        seqRun  = 2'b10,
        seqDone = 2'b11
    } seqState_e;

    // One iteration per operand bit
    localparam int iterCount = mcycleOpPkg::dataWidth;

    // Wide enough to hold iterCount
    localparam int iterCntWidth = 6;

endpackage

// File: mcycleOpPkg.sv
package mcycleOpPkg;

    ////////////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////////////

    localparam int dataWidth = 32;
    localparam int tagWidth  = 4;

    ////////////////////////////////////////////////////////////////////
    // Unsigned opcodes
    ////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        opMulLo   = 2'b00,
        opMulHi   = 2'b01,
        opDivQuot = 2'b10,
        opDivRem  = 2'b11
    } mcycleOp_e;

    // Request as issued by the pipeline
    typedef struct packed {
        mcycleOp_e            op;
        logic [dataWidth-1:0] operand1;  // multiplicand or dividend
        logic [dataWidth-1:0] operand2;  // multiplier or divisor
        logic [tagWidth-1:0]  dest;
    } mcycleReq_t;

    // Decoded command for the engine
    typedef struct packed {
        logic                 isDiv;
        logic                 takeHigh;  // high product or remainder
        logic [dataWidth-1:0] operand1;
        logic [dataWidth-1:0] operand2;
        logic [tagWidth-1:0]  dest;
    } mcycleCmd_t;

    // Tagged result toward writeback
    typedef struct packed {
        logic [dataWidth-1:0] data;
        logic [tagWidth-1:0]  dest;
    } mcycleRes_t;

endpackage
